//--- all.f
+incdir+common
common/sp_pkg.sv
src/sync_fifo.sv
scratchpad_bank/scratchpad_bank.sv
src/sp_write_arbiter.sv
src/gemm_tile_collector.sv
src/scratchpad_top.sv
sim/tb_clock_gen.sv
sim/tb_scratchpad.sv

//--- Makefile
SIM := obj_dir/Vtb_scratchpad

$(SIM): all.f $(wildcard common/* src/*.sv scratchpad_bank/*.sv sim/*.sv)
	verilator --binary --timing -f all.f --top-module tb_scratchpad -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- sim/tb_scratchpad.sv
`timescale 1ns/1ps
`include "sp_consts.svh"

module tb_scratchpad;

    import sp_pkg::*;

    logic       CLK, nRST;
    logic       load_wen, gemm_wen, rd_req_en, dram_ren;
    sp_wr_t     load_wdata, gemm_wdata;
    sp_rd_req_t rd_req;
    logic       load_busy, load_complete, gemm_complete, dram_empty, tile_valid;
    dram_rd_t   dram_rdata;
    gemm_tile_t tile;

    logic [31:0]             lfsr = 32'h43fc_77d7;
    logic [`SP_ROW_BITS-1:0] m_mats [`SP_MATS][`SP_ROWS];
    logic                    m_hold_valid;
    sp_wr_t                  m_hold_wr;
    dram_rd_t                dq [$];    // dram fifo contents
    gemm_tile_t              last_tile;
    int                      tile_cnt, err_cnt, to_cnt, drop_cnt;

    tb_clock_gen clk0 (.CLK(CLK), .nRST(nRST));

    scratchpad_top dut0 (
        .CLK(CLK), .nRST(nRST),
        .load_wen(load_wen), .load_wdata(load_wdata),
        .gemm_wen(gemm_wen), .gemm_wdata(gemm_wdata),
        .rd_req_en(rd_req_en), .rd_req(rd_req), .dram_ren(dram_ren),
        .load_busy(load_busy), .load_complete(load_complete),
        .gemm_complete(gemm_complete), .dram_empty(dram_empty),
        .dram_rdata(dram_rdata), .tile_valid(tile_valid), .tile(tile)
    );

    function automatic logic lfsr_step();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [63:0] take_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic sp_wr_t make_write();
        sp_wr_t      w;
        logic [63:0] r;
        r             = take_bits(5);
        w.gemm_result = r[4];       // overridden by the source port
        w.mat_s       = r[3:2];
        w.row_s       = r[1:0];
        w.data        = take_bits(64);
        return w;
    endfunction

    function automatic sp_rd_req_t make_request(logic [1:0] mt);
        sp_rd_req_t  q;
        logic [63:0] r;
        r       = take_bits(36);
        q.mat_t = mt;
        q.mat_s = r[35:34];
        q.row_s = r[33:32];
        q.addr  = r[31:0];
        return q;
    endfunction

    task automatic report_mismatch(string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic clear_inputs();
        load_wen  = 1'b0;
        gemm_wen  = 1'b0;
        rd_req_en = 1'b0;
        dram_ren  = 1'b0;
    endtask

    // called at a falling edge with inputs driven and returns at the next one
    task automatic step_cycle();
        sp_wr_t   w;
        logic     w_en, exp_lc, exp_gc, dram_full;
        dram_rd_t e;
        #5;
        w_en = 1'b1;
        if (gemm_wen) begin
            w             = gemm_wdata;
            w.gemm_result = 1'b1;
        end else if (m_hold_valid) begin
            w = m_hold_wr;
        end else if (load_wen) begin
            w             = load_wdata;
            w.gemm_result = 1'b0;
        end else begin
            w    = '0;
            w_en = 1'b0;
        end
        exp_lc = w_en && !w.gemm_result && (w.row_s == 2'd3);
        exp_gc = w_en && w.gemm_result && (w.row_s == 2'd3);
        if (load_busy !== m_hold_valid) begin
            report_mismatch($sformatf("load_busy %b, expected %b", load_busy, m_hold_valid));
        end
        if (load_complete !== exp_lc) begin
            report_mismatch($sformatf("load_complete %b, expected %b", load_complete, exp_lc));
        end
        if (gemm_complete !== exp_gc) begin
            report_mismatch($sformatf("gemm_complete %b, expected %b", gemm_complete, exp_gc));
        end
        if (dram_empty !== (dq.size() == 0)) begin
            report_mismatch($sformatf("dram_empty %b with %0d queued", dram_empty, dq.size()));
        end else if (dq.size() > 0 && dram_rdata !== dq[0]) begin
            report_mismatch($sformatf("dram_rdata %h, expected %h", dram_rdata, dq[0]));
        end
        if (tile_valid === 1'b1) begin
            tile_cnt++;
            last_tile = tile;
        end
        // model state at the coming edge
        dram_full = (dq.size() == `SP_DRAM_DEPTH);
        if (dram_ren && dq.size() > 0) begin
            void'(dq.pop_front());
        end
        if (rd_req_en && rd_req.mat_t == 2'd0) begin
            if (dram_full) begin
                drop_cnt++;
            end else begin
                e.addr  = rd_req.addr;
                e.mat_s = rd_req.mat_s;
                e.row_s = rd_req.row_s;
                e.data  = m_mats[rd_req.mat_s][rd_req.row_s];  // old value
                dq.push_back(e);
            end
        end
        if (w_en) begin
            m_mats[w.mat_s][w.row_s] = w.data;
        end
        if (m_hold_valid && !gemm_wen) begin
            m_hold_valid = 1'b0;    // held load went out this cycle
        end else if (!m_hold_valid && load_wen && gemm_wen) begin
            m_hold_valid          = 1'b1;
            m_hold_wr             = load_wdata;
            m_hold_wr.gemm_result = 1'b0;
        end
        @(negedge CLK);
    endtask

    task automatic readback_all();
        for (int m = 0; m < `SP_MATS; m++) begin
            for (int r = 0; r < `SP_ROWS; r++) begin
                clear_inputs();
                rd_req_en    = 1'b1;
                rd_req       = make_request(2'd0);
                rd_req.mat_s = m[1:0];
                rd_req.row_s = r[1:0];
                dram_ren     = (dq.size() > 0);
                step_cycle();
            end
        end
        clear_inputs();
    endtask

    task automatic drain_dram();
        int n;
        n = 0;
        clear_inputs();
        while (dq.size() > 0 && n < 20) begin
            dram_ren = 1'b1;
            step_cycle();
            n++;
        end
        dram_ren = 1'b0;
        if (dq.size() > 0) begin
            $display("DRAM FIFO did not drain within 20 cycles");
            to_cnt++;
        end
    endtask

    initial begin
        int          waited, cnt_before, t;
        int          order [3];
        logic [63:0] rv;
        logic [1:0]  mt;
        gemm_tile_t  exp_tile;
        clear_inputs();
        load_wdata   = '0;
        gemm_wdata   = '0;
        rd_req       = '0;
        m_hold_valid = 1'b0;
        m_hold_wr    = '0;
        tile_cnt     = 0;
        err_cnt      = 0;
        to_cnt       = 0;
        drop_cnt     = 0;
        for (int m = 0; m < `SP_MATS; m++) begin
            for (int r = 0; r < `SP_ROWS; r++) begin
                m_mats[m][r] = '0;
            end
        end
        waited = 0;
        while (nRST !== 1'b1 && waited < 20) begin
            @(negedge CLK);
            waited++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was never released");
            to_cnt++;
        end

        // reset state and zero storage
        step_cycle();
        if (tile_cnt != 0) begin
            report_mismatch("tile_valid high after reset");
        end
        readback_all();
        drain_dram();

        // random writes with collisions and dram reads under back-pressure
        for (int i = 0; i < 300; i++) begin
            rv         = take_bits(6);
            gemm_wen   = rv[0] && rv[1];
            load_wen   = rv[2] && !m_hold_valid;
            load_wdata = make_write();
            gemm_wdata = make_write();
            rd_req_en  = rv[3];
            rd_req     = make_request(2'd0);
            dram_ren   = rv[4] && rv[5] && (dq.size() > 0);
            step_cycle();
        end
        drain_dram();

        // read and write of the same row in one cycle
        for (int i = 0; i < 4; i++) begin
            gemm_wen     = 1'b1;
            gemm_wdata   = make_write();
            rd_req_en    = 1'b1;
            rd_req       = make_request(2'd0);
            rd_req.mat_s = gemm_wdata.mat_s;
            rd_req.row_s = gemm_wdata.row_s;
            dram_ren     = (dq.size() > 0);
            step_cycle();
        end
        clear_inputs();
        readback_all();
        drain_dram();

        // gemm tiles with rows 0..2 shuffled and row 3 last
        for (int m = 0; m < `SP_MATS; m++) begin
            rv    = take_bits(2);
            mt    = (rv[1:0] == 2'd0) ? 2'd1 : rv[1:0];
            order = '{0, 1, 2};
            for (int k = 2; k > 0; k--) begin
                rv       = take_bits(2);
                t        = int'(rv[1:0]) % (k + 1);
                waited   = order[k];
                order[k] = order[t];
                order[t] = waited;
            end
            exp_tile.mat_t = mt;
            exp_tile.mat_s = m[1:0];
            for (int r = 0; r < `SP_ROWS; r++) begin
                exp_tile.data[r] = m_mats[m][r];
            end
            cnt_before = tile_cnt;
            for (int k = 0; k < 4; k++) begin
                rd_req_en    = 1'b1;
                rd_req       = make_request(mt);
                rd_req.mat_s = m[1:0];
                rd_req.row_s = (k == 3) ? 2'd3 : order[k][1:0];
                step_cycle();
            end
            clear_inputs();
            waited = 0;
            while (tile_cnt == cnt_before && waited < 20) begin
                step_cycle();
                waited++;
            end
            if (tile_cnt == cnt_before) begin
                $display("no tile_valid after the GEMM reads of matrix %0d", m);
                to_cnt++;
            end else if (last_tile !== exp_tile) begin
                report_mismatch($sformatf("tile %h, expected %h", last_tile, exp_tile));
            end
            repeat (4) step_cycle();
            if (tile_cnt != cnt_before + 1) begin
                report_mismatch($sformatf("%0d tile_valid pulses for one tile",
                                          tile_cnt - cnt_before));
            end
        end

        $display("errors %0d, timeouts %0d, dropped reads %0d", err_cnt, to_cnt, drop_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;     // 40 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

//--- src/scratchpad_top.sv
`timescale 1ns/1ps

module scratchpad_top (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               load_wen,
    input  sp_pkg::sp_wr_t     load_wdata,
    input  logic               gemm_wen,
    input  sp_pkg::sp_wr_t     gemm_wdata,
    input  logic               rd_req_en,
    input  sp_pkg::sp_rd_req_t rd_req,
    input  logic               dram_ren,
    output logic               load_busy,
    output logic               load_complete,
    output logic               gemm_complete,
    output logic               dram_empty,
    output sp_pkg::dram_rd_t   dram_rdata,
    output logic               tile_valid,
    output sp_pkg::gemm_tile_t tile
);

    import sp_pkg::*;

    logic     wr_en;
    sp_wr_t   wr;
    logic     gemm_ren, gemm_empty;
    gemm_rd_t gemm_rdata;

    sp_write_arbiter arb0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .load_wen   (load_wen),
        .gemm_wen   (gemm_wen),
        .load_wdata (load_wdata),
        .gemm_wdata (gemm_wdata),
        .wr_en      (wr_en),
        .wr         (wr),
        .load_busy  (load_busy)
    );

    scratchpad_bank bank0 (
        .CLK           (CLK),
        .nRST          (nRST),
        .wr_en         (wr_en),
        .wr            (wr),
        .rd_req_en     (rd_req_en),
        .rd_req        (rd_req),
        .load_complete (load_complete),
        .gemm_complete (gemm_complete),
        .dram_ren      (dram_ren),
        .dram_empty    (dram_empty),
        .dram_rdata    (dram_rdata),
        .gemm_ren      (gemm_ren),
        .gemm_empty    (gemm_empty),
        .gemm_rdata    (gemm_rdata)
    );

    gemm_tile_collector coll0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .fifo_empty (gemm_empty),
        .fifo_rdata (gemm_rdata),
        .fifo_ren   (gemm_ren),
        .tile_valid (tile_valid),
        .tile       (tile)
    );

endmodule

//--- src/gemm_tile_collector.sv
`timescale 1ns/1ps
`include "sp_consts.svh"

module gemm_tile_collector (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               fifo_empty,
    input  sp_pkg::gemm_rd_t   fifo_rdata,
    output logic               fifo_ren,
    output logic               tile_valid,
    output sp_pkg::gemm_tile_t tile
);

    import sp_pkg::*;

    localparam logic [`SP_ROW_W-1:0] LAST_ROW = {`SP_ROW_W{1'b1}};

    logic [`SP_ROWS-1:0][`SP_ROW_BITS-1:0] stage;
    logic [`SP_ROWS-1:0][`SP_ROW_BITS-1:0] stage_next;
    logic                                  last_pop;

    assign fifo_ren = !fifo_empty;  // never back-pressures
    assign last_pop = fifo_ren && (fifo_rdata.row_s == LAST_ROW);

    // staging with the popped row dropped in
    always_comb begin
        stage_next = stage;
        stage_next[fifo_rdata.row_s] = fifo_rdata.data;
    end

    always_ff @(posedge CLK) begin
        if (fifo_ren) begin
            stage <= stage_next;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tile_valid <= 1'b0;
        end else begin
            tile_valid <= last_pop;     // one cycle pulse
        end
    end

    // type and select come from the row 3 entry
    always_ff @(posedge CLK) begin
        if (last_pop) begin
            tile.mat_t <= fifo_rdata.mat_t;
            tile.mat_s <= fifo_rdata.mat_s;
            tile.data  <= stage_next;
        end
    end

endmodule

//--- src/sp_write_arbiter.sv
`timescale 1ns/1ps

module sp_write_arbiter (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           load_wen,
    input  logic           gemm_wen,
    input  sp_pkg::sp_wr_t load_wdata,
    input  sp_pkg::sp_wr_t gemm_wdata,
    output logic           wr_en,
    output sp_pkg::sp_wr_t wr,
    output logic           load_busy
);

    import sp_pkg::*;

    logic   hold_valid;
    sp_wr_t hold_wr;
    sp_wr_t load_tagged;

    // source decides the completion flag
    always_comb begin
        load_tagged             = load_wdata;
        load_tagged.gemm_result = 1'b0;
    end

    // gemm first, then held load, then a fresh load
    always_comb begin
        wr_en = gemm_wen || hold_valid || load_wen;
        if (gemm_wen) begin
            wr             = gemm_wdata;
            wr.gemm_result = 1'b1;
        end else if (hold_valid) begin
            wr = hold_wr;
        end else begin
            wr = load_tagged;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            hold_valid <= 1'b0;
        end else if (hold_valid) begin
            hold_valid <= gemm_wen;     // stays put while gemm keeps the port
        end else begin
            hold_valid <= load_wen && gemm_wen;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold_valid && load_wen && gemm_wen) begin
            hold_wr <= load_tagged;
        end
    end

    assign load_busy = hold_valid;  // new loads ignored meanwhile

endmodule

//--- scratchpad_bank/scratchpad_bank.sv
`timescale 1ns/1ps
`include "sp_consts.svh"

module scratchpad_bank (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               wr_en,
    input  sp_pkg::sp_wr_t     wr,
    input  logic               rd_req_en,
    input  sp_pkg::sp_rd_req_t rd_req,
    output logic               load_complete,
    output logic               gemm_complete,
    input  logic               dram_ren,
    output logic               dram_empty,
    output sp_pkg::dram_rd_t   dram_rdata,
    input  logic               gemm_ren,
    output logic               gemm_empty,
    output sp_pkg::gemm_rd_t   gemm_rdata
);

    import sp_pkg::*;

    localparam logic [`SP_ROW_W-1:0] LAST_ROW = {`SP_ROW_W{1'b1}};  // row 3

    logic [`SP_MATS-1:0][`SP_ROWS-1:0][`SP_ROW_BITS-1:0] mats;
    logic [`SP_ROW_BITS-1:0] rd_data;
    logic                    to_dram;
    logic                    dram_wen, dram_full;
    logic                    gemm_wen, gemm_full;
    dram_rd_t                dram_wdata;
    gemm_rd_t                gemm_wdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mats <= '0;
        end else if (wr_en) begin
            mats[wr.mat_s][wr.row_s] <= wr.data;
        end
    end

    // last row of a matrix written
    assign load_complete = wr_en && !wr.gemm_result && (wr.row_s == LAST_ROW);
    assign gemm_complete = wr_en &&  wr.gemm_result && (wr.row_s == LAST_ROW);

    // reads see the array before this cycle's write
    assign rd_data = mats[rd_req.mat_s][rd_req.row_s];

    assign to_dram  = (rd_req.mat_t == '0);
    assign dram_wen = rd_req_en &&  to_dram && !dram_full;  // drop if queue full
    assign gemm_wen = rd_req_en && !to_dram && !gemm_full;

    always_comb begin
        dram_wdata.addr  = rd_req.addr;
        dram_wdata.mat_s = rd_req.mat_s;
        dram_wdata.row_s = rd_req.row_s;
        dram_wdata.data  = rd_data;

        gemm_wdata.mat_t = rd_req.mat_t;
        gemm_wdata.mat_s = rd_req.mat_s;
        gemm_wdata.row_s = rd_req.row_s;
        gemm_wdata.data  = rd_data;
    end

    sync_fifo #(.T(dram_rd_t), .DEPTH(`SP_DRAM_DEPTH)) dram_fifo (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (dram_wen),
        .ren   (dram_ren),
        .wdata (dram_wdata),
        .rdata (dram_rdata),
        .full  (dram_full),
        .empty (dram_empty)
    );

    sync_fifo #(.T(gemm_rd_t), .DEPTH(`SP_GEMM_DEPTH)) gemm_fifo (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (gemm_wen),
        .ren   (gemm_ren),
        .wdata (gemm_wdata),
        .rdata (gemm_rdata),
        .full  (gemm_full),
        .empty (gemm_empty)
    );

endmodule

//--- src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic CLK,
    input  logic nRST,
    input  logic wen,
    input  logic ren,
    input  T     wdata,
    output T     rdata,
    output logic full,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] MAX_CNT  = CNT_W'(DEPTH);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wptr, rptr;
    logic [CNT_W-1:0] count;
    logic             do_wr, do_rd;

    assign do_wr = wen && !full;    // write when full is dropped
    assign do_rd = ren && !empty;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= (wptr == LAST_PTR) ? '0 : wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= (rptr == LAST_PTR) ? '0 : rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_wr) begin
            mem[wptr] <= wdata;
        end
    end

    // show-ahead so the head entry is always on rdata
    assign rdata = mem[rptr];
    assign empty = (count == '0);
    assign full  = (count == MAX_CNT);

endmodule

//--- common/sp_pkg.sv
`include "sp_consts.svh"

package sp_pkg;

    // one row write into the bank
    typedef struct packed {
        logic                     gemm_result;  // 0 means dram load
        logic [`SP_MAT_W-1:0]     mat_s;
        logic [`SP_ROW_W-1:0]     row_s;
        logic [`SP_ROW_BITS-1:0]  data;
    } sp_wr_t;

    // read request routed by mat_t
    typedef struct packed {
        logic [`SP_TYPE_W-1:0]    mat_t;
        logic [`SP_MAT_W-1:0]     mat_s;
        logic [`SP_ROW_W-1:0]     row_s;
        logic [`SP_ADDR_W-1:0]    addr;
    } sp_rd_req_t;

    typedef struct packed {
        logic [`SP_ADDR_W-1:0]    addr;
        logic [`SP_MAT_W-1:0]     mat_s;
        logic [`SP_ROW_W-1:0]     row_s;
        logic [`SP_ROW_BITS-1:0]  data;
    } dram_rd_t;

    typedef struct packed {
        logic [`SP_TYPE_W-1:0]    mat_t;
        logic [`SP_MAT_W-1:0]     mat_s;
        logic [`SP_ROW_W-1:0]     row_s;
        logic [`SP_ROW_BITS-1:0]  data;
    } gemm_rd_t;

    // operand tile for the systolic array
    typedef struct packed {
        logic [`SP_TYPE_W-1:0]                    mat_t;
        logic [`SP_MAT_W-1:0]                     mat_s;
        logic [`SP_ROWS-1:0][`SP_ROW_BITS-1:0]    data;
    } gemm_tile_t;

endpackage

//--- common/sp_consts.svh
`ifndef SP_CONSTS_SVH
`define SP_CONSTS_SVH

// bank geometry
`define SP_MATS       4
`define SP_ROWS       4     // fixed by tile shape
`define SP_ROW_BITS   64
`define SP_MAT_W      2
`define SP_ROW_W      2

// request fields
`define SP_ADDR_W     32
`define SP_TYPE_W     2

// output queue depths
`define SP_DRAM_DEPTH 4
`define SP_GEMM_DEPTH 8

`endif
